// ==== miner_settings.svh ====
`ifndef MINER_SETTINGS_SVH
`define MINER_SETTINGS_SVH

// compression rounds per block.
`define SHA_ROUNDS 64

// block header width in bits.
`define HEADER_BITS 640

// initial hash words.
`define SHA_H0 32'h6a09e667
`define SHA_H1 32'hbb67ae85
`define SHA_H2 32'h3c6ef372
`define SHA_H3 32'ha54ff53a
`define SHA_H4 32'h510e527f
`define SHA_H5 32'h9b05688c
`define SHA_H6 32'h1f83d9ab
`define SHA_H7 32'h5be0cd19

`endif

// ==== minerPkg.sv ====
`include "miner_settings.svh"

package minerPkg;

	typedef struct packed {
		logic [31:0] a; // top bits.
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [31:0] e;
		logic [31:0] f;
		logic [31:0] g;
		logic [31:0] h;
	} hashState;

	// loaded raw, read back by the schedule as words.
	typedef union packed {
		logic [511:0] raw;
		logic [15:0][31:0] words; // words[15] is the first word.
	} shaBlock;

	typedef struct packed {
		logic [`HEADER_BITS-1:0] header; // byte 0 in the top bits.
		logic [31:0] firstNonce;
		logic [31:0] lastNonce;
		logic [255:0] target; // compared against the reversed digest.
	} minerJob;

	typedef struct packed {
		logic busy;
		logic done;
		logic found;
		logic [31:0] nonce; // numeric value.
		logic [255:0] hash; // SHA byte order.
	} minerStatus;

endpackage

// ==== sha256RoundRom.sv ====
`timescale 1ns/1ps
`include "miner_settings.svh"

module sha256RoundRom (
	input  logic [$clog2(`SHA_ROUNDS)-1:0] index,
	output logic [31:0] constant
);

	always_comb begin
		case (index)
			6'd0: constant = 32'h428a2f98;
			6'd1: constant = 32'h71374491;
			6'd2: constant = 32'hb5c0fbcf;
			6'd3: constant = 32'he9b5dba5;
			6'd4: constant = 32'h3956c25b;
			6'd5: constant = 32'h59f111f1;
			6'd6: constant = 32'h923f82a4;
			6'd7: constant = 32'hab1c5ed5;
			6'd8: constant = 32'hd807aa98;
			6'd9: constant = 32'h12835b01;
			6'd10: constant = 32'h243185be;
			6'd11: constant = 32'h550c7dc3;
			6'd12: constant = 32'h72be5d74;
			6'd13: constant = 32'h80deb1fe;
			6'd14: constant = 32'h9bdc06a7;
			6'd15: constant = 32'hc19bf174;
			6'd16: constant = 32'he49b69c1;
			6'd17: constant = 32'hefbe4786;
			6'd18: constant = 32'h0fc19dc6;
			6'd19: constant = 32'h240ca1cc;
			6'd20: constant = 32'h2de92c6f;
			6'd21: constant = 32'h4a7484aa;
			6'd22: constant = 32'h5cb0a9dc;
			6'd23: constant = 32'h76f988da;
			6'd24: constant = 32'h983e5152;
			6'd25: constant = 32'ha831c66d;
			6'd26: constant = 32'hb00327c8;
			6'd27: constant = 32'hbf597fc7;
			6'd28: constant = 32'hc6e00bf3;
			6'd29: constant = 32'hd5a79147;
			6'd30: constant = 32'h06ca6351;
			6'd31: constant = 32'h14292967;
			6'd32: constant = 32'h27b70a85;
			6'd33: constant = 32'h2e1b2138;
			6'd34: constant = 32'h4d2c6dfc;
			6'd35: constant = 32'h53380d13;
			6'd36: constant = 32'h650a7354;
			6'd37: constant = 32'h766a0abb;
			6'd38: constant = 32'h81c2c92e;
			6'd39: constant = 32'h92722c85;
			6'd40: constant = 32'ha2bfe8a1;
			6'd41: constant = 32'ha81a664b;
			6'd42: constant = 32'hc24b8b70;
			6'd43: constant = 32'hc76c51a3;
			6'd44: constant = 32'hd192e819;
			6'd45: constant = 32'hd6990624;
			6'd46: constant = 32'hf40e3585;
			6'd47: constant = 32'h106aa070;
			6'd48: constant = 32'h19a4c116;
			6'd49: constant = 32'h1e376c08;
			6'd50: constant = 32'h2748774c;
			6'd51: constant = 32'h34b0bcb5;
			6'd52: constant = 32'h391c0cb3;
			6'd53: constant = 32'h4ed8aa4a;
			6'd54: constant = 32'h5b9cca4f;
			6'd55: constant = 32'h682e6ff3;
			6'd56: constant = 32'h748f82ee;
			6'd57: constant = 32'h78a5636f;
			6'd58: constant = 32'h84c87814;
			6'd59: constant = 32'h8cc70208;
			6'd60: constant = 32'h90befffa;
			6'd61: constant = 32'ha4506ceb;
			6'd62: constant = 32'hbef9a3f7;
			6'd63: constant = 32'hc67178f2;
		endcase
	end

endmodule

// ==== sha256Core.sv ====
`timescale 1ns/1ps
`include "miner_settings.svh"

module sha256Core import minerPkg::*; (
	input  logic clock,
	input  logic reset,
	input  logic load,
	input  shaBlock block,
	input  hashState seed,
	output hashState digest,
	output logic digestValid
);

	localparam int IndexBits = $clog2(`SHA_ROUNDS);
	localparam int CountBits = IndexBits + 1;

	logic running;
	logic [CountBits-1:0] round; // rounds done so far.
	logic lastRound;
	hashState seedReg;
	hashState work;
	hashState nextWork;
	logic [15:0][31:0] window; // window[15] is W[t].
	logic [31:0] newWord;
	logic [31:0] roundConst;
	logic [31:0] temp1;
	logic [31:0] temp2;

	function automatic logic [31:0] rotr(input logic [31:0] x, input int amount);
		return (x >> amount) | (x << (32 - amount));
	endfunction

	function automatic logic [31:0] bigSigma0(input logic [31:0] x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic logic [31:0] bigSigma1(input logic [31:0] x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic logic [31:0] smallSigma0(input logic [31:0] x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic logic [31:0] smallSigma1(input logic [31:0] x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	function automatic hashState addState(input hashState x, input hashState y);
		hashState sum;
		sum.a = x.a + y.a;
		sum.b = x.b + y.b;
		sum.c = x.c + y.c;
		sum.d = x.d + y.d;
		sum.e = x.e + y.e;
		sum.f = x.f + y.f;
		sum.g = x.g + y.g;
		sum.h = x.h + y.h;
		return sum;
	endfunction

	sha256RoundRom roundRom (
		.index(round[IndexBits-1:0]),
		.constant(roundConst)
	);

	assign lastRound = (round == CountBits'(`SHA_ROUNDS));

	// W[t+16] from W[t+14], W[t+9], W[t+1] and W[t].
	assign newWord = smallSigma1(window[1]) + window[6] + smallSigma0(window[14]) + window[15];

	always_comb begin
		temp1 = work.h + bigSigma1(work.e) + ((work.e & work.f) ^ (~work.e & work.g))
			+ roundConst + window[15];
		temp2 = bigSigma0(work.a) + ((work.a & work.b) ^ (work.a & work.c) ^ (work.b & work.c));
		nextWork.a = temp1 + temp2;
		nextWork.b = work.a;
		nextWork.c = work.b;
		nextWork.d = work.c;
		nextWork.e = work.d + temp1;
		nextWork.f = work.e;
		nextWork.g = work.f;
		nextWork.h = work.g;
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			running <= 1'b0;
			round <= '0;
			digestValid <= 1'b0;
		end else begin
			digestValid <= 1'b0;
			if (load) begin
				running <= 1'b1;
				round <= '0;
			end else if (running) begin
				if (lastRound) begin
					running <= 1'b0;
					digestValid <= 1'b1; // one cycle after the chaining add.
				end else begin
					round <= round + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			seedReg <= seed;
			work <= seed;
			window <= block.words;
		end else if (running) begin
			if (lastRound) begin
				digest <= addState(seedReg, work);
			end else begin
				work <= nextWork;
				window <= {window[14:0], newWord}; // shift in the next schedule word.
			end
		end
	end

endmodule

// ==== minerControl.sv ====
`timescale 1ns/1ps
`include "miner_settings.svh"

module minerControl import minerPkg::*; (
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  minerJob job,
	output minerStatus status
);

	localparam logic [1:0] phaseIdle = 2'd0;
	localparam logic [1:0] phaseMid = 2'd1;
	localparam logic [1:0] phaseSecond = 2'd2;
	localparam logic [1:0] phaseFinal = 2'd3;
	localparam hashState initHash = {`SHA_H0, `SHA_H1, `SHA_H2, `SHA_H3,
		`SHA_H4, `SHA_H5, `SHA_H6, `SHA_H7};

	minerJob jobReg;
	hashState midstate;
	logic [1:0] phase; // pass now in the core.
	logic [1:0] loadPhase; // pass issued this cycle.
	logic kickoff;
	logic accept;
	logic [31:0] nonceCnt;
	logic [31:0] nonceNext;
	logic [31:0] nonceSwapped;
	logic coreLoad;
	shaBlock coreBlock;
	hashState coreSeed;
	hashState coreDigest;
	logic digestValid;
	logic [255:0] reversed;
	logic hit;
	logic atLast;
	logic finish;
	logic busy;
	logic done;
	logic found;
	logic [31:0] resultNonce;
	logic [255:0] resultHash;

	assign accept = start & ~busy;

	assign reversed = {<<8{coreDigest}}; // little-endian view of the digest.
	assign hit = (reversed < jobReg.target);
	assign atLast = (nonceCnt == jobReg.lastNonce);
	assign finish = digestValid & (phase == phaseFinal) & (hit | atLast);

	assign nonceNext = (phase == phaseFinal) ? nonceCnt + 32'd1 : nonceCnt;
	assign nonceSwapped = {<<8{nonceNext}}; // header holds it little-endian.

	always_comb begin
		loadPhase = phaseIdle;
		if (kickoff) begin
			loadPhase = phaseMid;
		end else if (digestValid && !finish) begin
			case (phase)
				phaseMid: loadPhase = phaseSecond;
				phaseSecond: loadPhase = phaseFinal;
				phaseFinal: loadPhase = phaseSecond; // next nonce.
				default: loadPhase = phaseIdle;
			endcase
		end
	end

	assign coreLoad = (loadPhase != phaseIdle);

	always_comb begin
		case (loadPhase)
			phaseSecond: coreBlock.raw = {jobReg.header[`HEADER_BITS-513:32], nonceSwapped,
				1'b1, 319'b0, 64'(`HEADER_BITS)};
			phaseFinal: coreBlock.raw = {coreDigest, 1'b1, 191'b0, 64'd256};
			default: coreBlock.raw = jobReg.header[`HEADER_BITS-1 -: 512];
		endcase
	end

	always_comb begin
		case (loadPhase)
			phaseSecond: coreSeed = (phase == phaseMid) ? coreDigest : midstate;
			default: coreSeed = initHash;
		endcase
	end

	sha256Core shaCore (
		.clock(clock),
		.reset(reset),
		.load(coreLoad),
		.block(coreBlock),
		.seed(coreSeed),
		.digest(coreDigest),
		.digestValid(digestValid)
	);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			phase <= phaseIdle;
			kickoff <= 1'b0;
			nonceCnt <= '0;
			busy <= 1'b0;
			done <= 1'b0;
			found <= 1'b0;
		end else begin
			kickoff <= accept;
			if (accept) begin
				nonceCnt <= job.firstNonce;
				busy <= 1'b1;
				done <= 1'b0;
				found <= 1'b0;
			end
			if (coreLoad) begin
				phase <= loadPhase;
			end else if (finish) begin
				phase <= phaseIdle;
				busy <= 1'b0;
				done <= 1'b1;
				found <= hit;
			end
			if (loadPhase == phaseSecond) begin
				nonceCnt <= nonceNext;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			jobReg <= job;
		end
		if (digestValid && phase == phaseMid) begin
			midstate <= coreDigest; // reused for every nonce.
		end
		if (finish) begin
			resultNonce <= nonceCnt;
			resultHash <= coreDigest;
		end
	end

	assign status = {busy, done, found, resultNonce, resultHash};

endmodule

// ==== minerTop.sv ====
`timescale 1ns/1ps

module minerTop import minerPkg::*; (
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  minerJob job,
	output minerStatus status
);

	minerJob jobWire;
	minerStatus statusWire;

	assign jobWire = job;
	assign status = statusWire;

	minerControl control (
		.clock(clock),
		.reset(reset),
		.start(start),
		.job(jobWire),
		.status(statusWire)
	);

endmodule

// ==== tbShaModel.svh ====
`ifndef TB_SHA_MODEL_SVH
`define TB_SHA_MODEL_SVH

localparam logic [0:`SHA_ROUNDS-1][31:0] modelK = {
	32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
	32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
	32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
	32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
	32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
	32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
	32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
	32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
	32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
	32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
	32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2};

function automatic logic [31:0] ror32(input logic [31:0] x, input int n);
	return (x >> n) | (x << (32 - n));
endfunction

// one block compression, word a in the top bits of the state.
function automatic logic [255:0] compress(input logic [255:0] state, input logic [511:0] msg);
	logic [31:0] w [`SHA_ROUNDS];
	logic [31:0] v [8];
	logic [31:0] s0;
	logic [31:0] s1;
	logic [31:0] t1;
	logic [31:0] t2;
	logic [255:0] next;
	for (int i = 0; i < 16; i++)
		w[i] = msg[511 - 32*i -: 32];
	for (int i = 16; i < `SHA_ROUNDS; i++) begin
		s0 = ror32(w[i-15], 7) ^ ror32(w[i-15], 18) ^ (w[i-15] >> 3);
		s1 = ror32(w[i-2], 17) ^ ror32(w[i-2], 19) ^ (w[i-2] >> 10);
		w[i] = w[i-16] + s0 + w[i-7] + s1;
	end
	for (int i = 0; i < 8; i++)
		v[i] = state[255 - 32*i -: 32];
	for (int i = 0; i < `SHA_ROUNDS; i++) begin
		s1 = ror32(v[4], 6) ^ ror32(v[4], 11) ^ ror32(v[4], 25);
		t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + modelK[i] + w[i];
		s0 = ror32(v[0], 2) ^ ror32(v[0], 13) ^ ror32(v[0], 22);
		t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
		for (int j = 7; j > 0; j--)
			v[j] = v[j-1];
		v[4] = v[4] + t1; // v[4] holds old d here.
		v[0] = t1 + t2;
	end
	for (int i = 0; i < 8; i++)
		next[255 - 32*i -: 32] = state[255 - 32*i -: 32] + v[i];
	return next;
endfunction

function automatic logic [255:0] initialHash();
	return {`SHA_H0, `SHA_H1, `SHA_H2, `SHA_H3, `SHA_H4, `SHA_H5, `SHA_H6, `SHA_H7};
endfunction

function automatic logic [31:0] swapBytes32(input logic [31:0] x);
	return {x[7:0], x[15:8], x[23:16], x[31:24]};
endfunction

function automatic logic [255:0] reverseBytes256(input logic [255:0] x);
	logic [255:0] r;
	for (int i = 0; i < 32; i++)
		r[8*i +: 8] = x[255 - 8*i -: 8];
	return r;
endfunction

// sha256 twice, nonce stored little-endian in header bytes 76 to 79.
function automatic logic [255:0] doubleHash(input logic [`HEADER_BITS-1:0] header,
	input logic [31:0] nonce);
	logic [1023:0] padded;
	logic [255:0] inner;
	padded = {header[`HEADER_BITS-1:32], swapBytes32(nonce), 1'b1, 319'b0, 64'(`HEADER_BITS)};
	inner = compress(initialHash(), padded[1023:512]);
	inner = compress(inner, padded[511:0]);
	return compress(initialHash(), {inner, 1'b1, 191'b0, 64'd256});
endfunction

`endif

// ==== tbMiner.sv ====
`timescale 1ns/1ps
`include "miner_settings.svh"

module tbMiner import minerPkg::*; ();

	localparam int cycleLimit = 6000; // about twice what the five tests need.
	localparam logic [`HEADER_BITS-1:0] genesisHeader = {32'h01000000, 256'h0,
		256'h3ba3edfd7a7b12b27ac72c3e67768f617fc81bc3888a51323a9fb8aa4b1e5e4a,
		32'h29ab5f49, 32'hffff001d, 32'h1dac2b7c};
	localparam logic [255:0] genesisTarget = 256'hffff << 208;
	localparam logic [255:0] genesisHash =
		256'h000000000019d6689c085ae165831e934ff763ae46a2a6c172b3f1b60a8ce26f;
	localparam logic [31:0] genesisNonce = 32'd2083236893;

	logic clock;
	logic reset;
	logic start;
	minerJob job;
	minerStatus status;
	integer seed;
	int cycles = 0;
	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	minerJob easyJob; // reused by the ignored start test.
	minerStatus easyExpected;

	`include "tbShaModel.svh"

	minerTop minerTop_inst (
		.clock(clock),
		.reset(reset),
		.start(start),
		.job(job),
		.status(status)
	);

	always #5 clock = ~clock;

	always @(posedge clock) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("run timed out after %0d cycles with a search still open", cycles);
			$display("Test failed");
			$finish;
		end
	end

	task automatic checkValue(input string testName, input string field,
		input logic [255:0] expected, input logic [255:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s %s: expected %h, actual %h", testName, field, expected, actual);
			errorCount++;
		end
	endtask

	task automatic checkStatus(input string testName, input minerStatus expected);
		checkValue(testName, "busy", expected.busy, status.busy);
		checkValue(testName, "done", expected.done, status.done);
		checkValue(testName, "found", expected.found, status.found);
		checkValue(testName, "nonce", expected.nonce, status.nonce);
		checkValue(testName, "hash", expected.hash, status.hash);
	endtask

	task automatic reportTest(input string testName, input int errorsBefore);
		if (errorCount == errorsBefore) begin
			$display("%s: ok", testName);
			passCount++;
		end else begin
			$display("%s: %0d mismatches", testName, errorCount - errorsBefore);
			failCount++;
		end
	endtask

	task automatic randomHeader(output logic [`HEADER_BITS-1:0] header);
		for (int i = 0; i < `HEADER_BITS / 32; i++)
			header[32*i +: 32] = $random(seed);
	endtask

	// first nonce whose reversed digest is below target, else the last nonce.
	function automatic minerStatus expectedStatus(input minerJob j);
		minerStatus s;
		logic [255:0] digest;
		logic [32:0] n;
		s = '0;
		s.done = 1'b1;
		s.nonce = j.lastNonce;
		s.hash = doubleHash(j.header, j.lastNonce);
		for (n = {1'b0, j.firstNonce}; n <= {1'b0, j.lastNonce} && !s.found; n++) begin
			digest = doubleHash(j.header, n[31:0]);
			if (reverseBytes256(digest) < j.target) begin
				s.found = 1'b1;
				s.nonce = n[31:0];
				s.hash = digest;
			end
		end
		return s;
	endfunction

	task automatic pulseStart(input minerJob newJob);
		job = newJob;
		start = 1'b1;
		@(posedge clock);
		#1;
		start = 1'b0;
	endtask

	task automatic waitDone();
		while (!status.done) begin
			@(posedge clock);
			#1;
		end
	endtask

	task automatic testGenesis();
		minerJob j;
		minerStatus expected;
		int errorsBefore;
		errorsBefore = errorCount;
		j.header = genesisHeader;
		j.firstNonce = genesisNonce;
		j.lastNonce = genesisNonce;
		j.target = genesisTarget;
		expected = expectedStatus(j);
		checkValue("genesis header", "model hash", genesisHash, reverseBytes256(expected.hash));
		pulseStart(j);
		waitDone();
		checkStatus("genesis header", expected);
		checkValue("genesis header", "found", 1'b1, status.found);
		reportTest("genesis header", errorsBefore);
	endtask

	task automatic testEasyTarget();
		int errorsBefore;
		errorsBefore = errorCount;
		easyJob.firstNonce = 32'd1000;
		easyJob.lastNonce = 32'd1007;
		easyJob.target = 256'd1 << 252; // one hit in 16 on average.
		easyExpected.found = 1'b0;
		for (int tries = 0; tries < 50 && !easyExpected.found; tries++) begin
			randomHeader(easyJob.header);
			easyExpected = expectedStatus(easyJob);
		end
		pulseStart(easyJob);
		waitDone();
		checkStatus("easy target", easyExpected);
		checkValue("easy target", "found", 1'b1, status.found);
		reportTest("easy target", errorsBefore);
	endtask

	task automatic testZeroTarget();
		minerJob j;
		minerStatus expected;
		int errorsBefore;
		errorsBefore = errorCount;
		randomHeader(j.header);
		j.firstNonce = 32'h000000fe; // count carries into the next byte.
		j.lastNonce = 32'h00000100;
		j.target = '0;
		expected = expectedStatus(j);
		pulseStart(j);
		waitDone();
		checkStatus("zero target", expected);
		reportTest("zero target", errorsBefore);
	endtask

	task automatic testIgnoredStart();
		minerJob other;
		int errorsBefore;
		errorsBefore = errorCount;
		pulseStart(easyJob);
		repeat (100) begin
			@(posedge clock);
			#1;
		end
		checkValue("start while busy", "busy", 1'b1, status.busy);
		randomHeader(other.header);
		other.firstNonce = 32'd5;
		other.lastNonce = 32'd5;
		other.target = '1;
		pulseStart(other);
		waitDone();
		checkStatus("start while busy", easyExpected);
		reportTest("start while busy", errorsBefore);
	endtask

	task automatic testResetMidSearch();
		minerJob j;
		minerStatus expected;
		int errorsBefore;
		errorsBefore = errorCount;
		pulseStart(easyJob);
		repeat (80) begin
			@(posedge clock);
			#1;
		end
		reset = 1'b1;
		#1;
		checkValue("reset mid-search", "busy", 1'b0, status.busy);
		checkValue("reset mid-search", "done", 1'b0, status.done);
		checkValue("reset mid-search", "found", 1'b0, status.found);
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		randomHeader(j.header);
		j.firstNonce = 32'd7;
		j.lastNonce = 32'd8;
		j.target = 256'd1 << 254;
		expected = expectedStatus(j);
		pulseStart(j);
		waitDone();
		checkStatus("reset mid-search", expected);
		reportTest("reset mid-search", errorsBefore);
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		job = '0;
		seed = 29009;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		testGenesis();
		testEasyTarget();
		testZeroTarget();
		testIgnoredStart();
		testResetMidSearch();
		$display("tests ok: %0d, tests with mismatches: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+.
minerPkg.sv
sha256RoundRom.sv
sha256Core.sv
minerControl.sv
minerTop.sv
tbMiner.sv
